// ==== design/bus_pkg.sv ====
`default_nettype none

// ------------------------------------------------------------
// system bus definitions
// ------------------------------------------------------------

package bus_pkg;

	// word width on the bus
	// same width for address and data lines
	localparam int WORD_BITS = 16;

	// memory block number width
	// selects one of 16 blocks
	localparam int NB_BITS = 4;

	// bit 0 is the most significant bit
	// as on the real machine
	typedef logic [0:WORD_BITS-1] word_t;

	// block number as seen on nb_ lines
	typedef logic [0:NB_BITS-1] nb_t;

	// all bus lines are active low
	// a participant inverts at its own edge
	// the strobes w_ and r_ open a cycle
	// ok_ closes it under the interlock rule

	// address and data words share word_t
	// so a register can move between them

	// the block register feeds nb_ directly
	// no extra mapping in between

	// nothing here carries state

endpackage

`default_nettype wire

// ==== design/panel_pkg.sv ====
`default_nettype none

// ------------------------------------------------------------
// control panel key commands
// ------------------------------------------------------------

package panel_pkg;

	// command presented with key_stb
	// the key word kl travels beside it
	typedef enum logic [1:0] {
		// kl goes to the address register
		KEY_LOAD_AR = 2'd0,
		// kl goes to the block register
		KEY_LOAD_NB = 2'd1,
		// kl written at nb:ar
		KEY_STORE   = 2'd2,
		// word at nb:ar shown on w
		KEY_FETCH   = 2'd3
	} key_cmd_t;

	// loads finish in a single cycle
	// store and fetch need a bus cycle
	// both memory keys advance ar afterwards

endpackage

`default_nettype wire

// ==== design/puks.sv ====
`timescale 1ns/1ps
`default_nettype none

// power-up clear generator
// holds the machine in clear after reset
module puks #(
	parameter int CLEAR_CYCLES = 8
) (
	input wire clk,
	input wire arst_n,
	output logic clm_,
	output logic pon_
);

	// ------------------------------------------------------------
	// clear length counter
	// ------------------------------------------------------------

	// one extra state so the terminal count fits
	localparam int CNT_BITS = $clog2(CLEAR_CYCLES + 1);

	logic [CNT_BITS-1:0] cnt;
	logic cnt_end;

	// terminal count reached
	assign cnt_end = (cnt == CNT_BITS'(CLEAR_CYCLES));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (!cnt_end) begin
			cnt <= cnt + 1'b1;
		end
	end

	// ------------------------------------------------------------
	// clear and power-good outputs
	// ------------------------------------------------------------

	// clm_ low while clearing
	// pon_ low once power is good
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clm_ <= 1'b0;
			pon_ <= 1'b1;
		end else if (cnt_end) begin
			// clear done
			clm_ <= 1'b1;
			pon_ <= 1'b0;
		end
	end

	// both flip once and stay
	// only arst_n brings the clear back

endmodule

`default_nettype wire

// ==== design/panel_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

// control panel key sequencer
module panel_ctl (
	input wire clk,
	input wire arst_n,
	input wire clm_,
	input wire pon_,
	// keys
	input wire key_stb,
	input wire panel_pkg::key_cmd_t key_cmd,
	input wire bus_pkg::word_t kl,
	// bus stage
	input wire ack,
	input wire nomem,
	input wire bus_pkg::word_t rdt,
	output logic req,
	output logic req_write,
	output bus_pkg::nb_t req_nb,
	output bus_pkg::word_t req_ad,
	output bus_pkg::word_t req_dt,
	// status
	output logic busy,
	output logic done,
	output bus_pkg::word_t w,
	output logic alarm_
);

	import bus_pkg::*;
	import panel_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_DONE
	} state_t;

	state_t state;

	// address and block registers
	word_t ar;
	nb_t nb;

	logic accept;

	// keys only after power good
	assign accept = key_stb && !busy && !pon_;

	// busy covers the done cycle too
	assign busy = (state != ST_IDLE);
	assign done = (state == ST_DONE);

	// ------------------------------------------------------------
	// key sequencing
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			req       <= 1'b0;
			req_write <= 1'b0;
			ar        <= '0;
			nb        <= '0;
			w         <= '0;
			alarm_    <= 1'b1;
		end else if (!clm_) begin
			// master clear
			state     <= ST_IDLE;
			req       <= 1'b0;
			req_write <= 1'b0;
			ar        <= '0;
			nb        <= '0;
			alarm_    <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						// any accepted key drops the alarm
						alarm_ <= 1'b1;
						case (key_cmd)
							KEY_LOAD_AR: begin
								ar    <= kl;
								state <= ST_DONE;
							end
							KEY_LOAD_NB: begin
								// low bits of kl
								nb    <= nb_t'(kl);
								state <= ST_DONE;
							end
							KEY_STORE, KEY_FETCH: begin
								req       <= 1'b1;
								req_write <= (key_cmd == KEY_STORE);
								state     <= ST_BUS;
							end
						endcase
					end
				end
				ST_BUS: begin
					// request held until ack
					if (ack) begin
						req <= 1'b0;
						// ar advances even on a missing block
						ar  <= ar + 1'b1;
						if (nomem) begin
							alarm_ <= 1'b0;
						end else if (!req_write) begin
							w <= rdt;
						end
						state <= ST_DONE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// request payload
	// ------------------------------------------------------------

	// latched at acceptance, stable through the cycle
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && accept) begin
			req_nb <= nb;
			req_ad <= ar;
			req_dt <= kl;
		end
	end

endmodule

`default_nettype wire

// ==== design/bus_drv.sv ====
`timescale 1ns/1ps
`default_nettype none

// system bus cycle driver
// one interlocked cycle per request
module bus_drv #(
	parameter int NOMEM_CYCLES = 16
) (
	input wire clk,
	input wire arst_n,
	input wire clm_,
	// request side
	input wire req,
	input wire req_write,
	input wire bus_pkg::nb_t req_nb,
	input wire bus_pkg::word_t req_ad,
	input wire bus_pkg::word_t req_dt,
	output logic ack,
	output logic nomem,
	output bus_pkg::word_t rdt,
	// system bus
	output logic w_,
	output logic r_,
	output bus_pkg::nb_t nb_,
	output bus_pkg::word_t ad_,
	output bus_pkg::word_t dt_,
	input wire bus_pkg::word_t rdt_,
	input wire ok_
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STROBE,
		ST_RELEASE
	} state_t;

	localparam int CNT_BITS = (NOMEM_CYCLES > 1) ? $clog2(NOMEM_CYCLES) : 1;

	state_t state;
	logic [CNT_BITS-1:0] cnt;
	logic timed_out;
	logic cnt_end;

	// last cycle before timeout
	assign cnt_end = (cnt == CNT_BITS'(NOMEM_CYCLES - 1));

	// ------------------------------------------------------------
	// cycle state machine
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			w_        <= 1'b1;
			r_        <= 1'b1;
			nb_       <= '1;
			ad_       <= '1;
			dt_       <= '1;
			ack       <= 1'b0;
			nomem     <= 1'b0;
			cnt       <= '0;
			timed_out <= 1'b0;
		end else if (!clm_) begin
			// abort anything in flight
			state <= ST_IDLE;
			w_    <= 1'b1;
			r_    <= 1'b1;
			nb_   <= '1;
			ad_   <= '1;
			dt_   <= '1;
			ack   <= 1'b0;
			nomem <= 1'b0;
		end else begin
			ack   <= 1'b0;
			nomem <= 1'b0;
			case (state)
				ST_IDLE: begin
					// req still high during ack
					if (req && !ack) begin
						nb_       <= ~req_nb;
						ad_       <= ~req_ad;
						dt_       <= req_write ? ~req_dt : '1;
						w_        <= ~req_write;
						r_        <= req_write;
						cnt       <= '0;
						timed_out <= 1'b0;
						state     <= ST_STROBE;
					end
				end
				ST_STROBE: begin
					if (!ok_ || cnt_end) begin
						// release strobe, wait for ok_ to go
						w_        <= 1'b1;
						r_        <= 1'b1;
						timed_out <= ok_;
						state     <= ST_RELEASE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					// interlock
					if (ok_) begin
						ack   <= 1'b1;
						nomem <= timed_out;
						nb_   <= '1;
						ad_   <= '1;
						dt_   <= '1;
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// read data taken with ok_
	always_ff @(posedge clk) begin
		if (state == ST_STROBE && !ok_) begin
			rdt <= ~rdt_;
		end
	end

endmodule

`default_nettype wire

// ==== design/mem_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

// memory module on the system bus
// answers only for blocks 0 to MEM_BLOCKS-1
module mem_ctl #(
	parameter int MEM_BLOCKS = 2,
	parameter int MEM_ADDR_BITS = 8
) (
	input wire clk,
	input wire arst_n,
	// system bus
	input wire w_,
	input wire r_,
	input wire bus_pkg::nb_t nb_,
	input wire bus_pkg::word_t ad_,
	input wire bus_pkg::word_t dt_,
	output logic ok_,
	output bus_pkg::word_t rdt_
);

	import bus_pkg::*;

	// ------------------------------------------------------------
	// geometry
	// ------------------------------------------------------------

	localparam int BLK_BITS = (MEM_BLOCKS > 1) ? $clog2(MEM_BLOCKS) : 1;
	localparam int WORDS = MEM_BLOCKS << MEM_ADDR_BITS;
	localparam int IDX_BITS = BLK_BITS + MEM_ADDR_BITS;

	// blocks stacked one after another
	word_t mem [0:WORDS-1];

	nb_t nb;
	word_t ad;
	logic present;
	logic strobe;
	logic wr;
	logic rd;
	logic [IDX_BITS-1:0] idx;

	// bus lines to positive logic
	assign nb = ~nb_;
	assign ad = ~ad_;

	// block decode
	assign present = (nb < MEM_BLOCKS);

	// block in the high bits, word in the low bits
	assign idx = {BLK_BITS'(nb), MEM_ADDR_BITS'(ad)};

	assign strobe = !w_ || !r_;

	// act once per cycle, before ok_ drops
	assign wr = !w_ && present && ok_;
	assign rd = !r_ && present && ok_;

	// ------------------------------------------------------------
	// interlock
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ok_ <= 1'b1;
		end else if (!strobe) begin
			// strobe gone
			ok_ <= 1'b1;
		end else if (present) begin
			// absent blocks stay silent
			ok_ <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------

	// contents survive reset
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[idx] <= ~dt_;
		end
		if (rd) begin
			rdt_ <= ~mem[idx];
		end
	end

	// rdt_ stays valid while ok_ is low
	// the driver samples it on that edge

endmodule

`default_nettype wire

// ==== design/mera400_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// memory path top level
// clear generator, panel, bus driver and memory
module mera400_mem #(
	parameter int CLEAR_CYCLES = 8,
	parameter int NOMEM_CYCLES = 16,
	parameter int MEM_BLOCKS = 2,
	parameter int MEM_ADDR_BITS = 8
) (
	input wire clk,
	input wire arst_n,
	input wire key_stb,
	input wire panel_pkg::key_cmd_t key_cmd,
	input wire bus_pkg::word_t kl,
	output logic busy,
	output logic done,
	output bus_pkg::word_t w,
	output logic alarm_
);

	import bus_pkg::*;

	// ------------------------------------------------------------
	// power supply
	// ------------------------------------------------------------

	logic clm_;
	logic pon_;

	puks #(
		.CLEAR_CYCLES(CLEAR_CYCLES)
	) i_puks (
		.clk(clk),
		.arst_n(arst_n),
		.clm_(clm_),
		.pon_(pon_)
	);

	// ------------------------------------------------------------
	// panel
	// ------------------------------------------------------------

	logic req;
	logic req_write;
	nb_t req_nb;
	word_t req_ad;
	word_t req_dt;
	logic ack;
	logic nomem;
	word_t rdt;

	panel_ctl i_panel_ctl (
		.clk(clk),
		.arst_n(arst_n),
		.clm_(clm_),
		.pon_(pon_),
		.key_stb(key_stb),
		.key_cmd(key_cmd),
		.kl(kl),
		.ack(ack),
		.nomem(nomem),
		.rdt(rdt),
		.req(req),
		.req_write(req_write),
		.req_nb(req_nb),
		.req_ad(req_ad),
		.req_dt(req_dt),
		.busy(busy),
		.done(done),
		.w(w),
		.alarm_(alarm_)
	);

	// ------------------------------------------------------------
	// system bus
	// ------------------------------------------------------------

	logic w_;
	logic r_;
	logic ok_;
	nb_t nb_;
	word_t ad_;
	word_t dt_;
	word_t rdt_;

	bus_drv #(
		.NOMEM_CYCLES(NOMEM_CYCLES)
	) i_bus_drv (
		.clk(clk),
		.arst_n(arst_n),
		.clm_(clm_),
		.req(req),
		.req_write(req_write),
		.req_nb(req_nb),
		.req_ad(req_ad),
		.req_dt(req_dt),
		.ack(ack),
		.nomem(nomem),
		.rdt(rdt),
		.w_(w_),
		.r_(r_),
		.nb_(nb_),
		.ad_(ad_),
		.dt_(dt_),
		.rdt_(rdt_),
		.ok_(ok_)
	);

	// ------------------------------------------------------------
	// memory
	// ------------------------------------------------------------

	mem_ctl #(
		.MEM_BLOCKS(MEM_BLOCKS),
		.MEM_ADDR_BITS(MEM_ADDR_BITS)
	) i_mem_ctl (
		.clk(clk),
		.arst_n(arst_n),
		.w_(w_),
		.r_(r_),
		.nb_(nb_),
		.ad_(ad_),
		.dt_(dt_),
		.ok_(ok_),
		.rdt_(rdt_)
	);

endmodule

`default_nettype wire

// ==== test/tb_mera400_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// testbench for the memory path top level
module tb_mera400_mem;

	import bus_pkg::*;
	import panel_pkg::*;

	localparam int CLEAR_CYCLES = 8;
	localparam int MEM_ADDR_BITS = 8;
	localparam int RUNS = 4;
	localparam int RUN_LEN = 8;
	// dropped presses count as well
	localparam int NUM_KEYS = 6 + 10 * RUNS + 2 * RUN_LEN + 3 + 3 + 7;
	localparam int TIMEOUT_CYCLES = 200 + 40 * NUM_KEYS;

	logic clk = 1'b0;
	logic arst_n;
	logic key_stb;
	key_cmd_t key_cmd;
	word_t kl;
	logic busy;
	logic done;
	word_t w;
	logic alarm_;

	mera400_mem i_mera400_mem (
		.clk(clk),
		.arst_n(arst_n),
		.key_stb(key_stb),
		.key_cmd(key_cmd),
		.kl(kl),
		.busy(busy),
		.done(done),
		.w(w),
		.alarm_(alarm_)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	word_t model_ar;
	nb_t model_nb;
	word_t model_w;
	logic model_alarm;
	// one array per present block
	word_t blk0 [0:(1 << MEM_ADDR_BITS) - 1];
	word_t blk1 [0:(1 << MEM_ADDR_BITS) - 1];

	word_t exp_w;
	logic exp_alarm_;
	int seed = 32'h3b7b_69cc;
	int cycle_count = 0;

	// one accepted key applied to the model
	// returns the expected display word
	function automatic word_t ref_key(key_cmd_t cmd, word_t word);
		logic [MEM_ADDR_BITS-1:0] idx;
		idx = MEM_ADDR_BITS'(model_ar);
		// alarm cleared by any accepted key
		model_alarm = 1'b0;
		case (cmd)
			KEY_LOAD_AR: model_ar = word;
			KEY_LOAD_NB: model_nb = nb_t'(word);
			KEY_STORE: begin
				if (model_nb == 0) begin
					blk0[idx] = word;
				end else if (model_nb == 1) begin
					blk1[idx] = word;
				end else begin
					model_alarm = 1'b1;
				end
				model_ar = model_ar + 1'b1;
			end
			default: begin
				// fetch keeps w on a missing block
				if (model_nb == 0) begin
					model_w = blk0[idx];
				end else if (model_nb == 1) begin
					model_w = blk1[idx];
				end else begin
					model_alarm = 1'b1;
				end
				model_ar = model_ar + 1'b1;
			end
		endcase
		return model_w;
	endfunction

	function automatic word_t rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// address inside one block
	function automatic word_t rand_addr();
		logic [31:0] r;
		r = $random(seed);
		return word_t'(r[MEM_ADDR_BITS-1:0]);
	endfunction

	// ------------------------------------------------------------
	// checking
	// ------------------------------------------------------------

	task automatic abort_run(string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_alarm(logic got, logic exp);
		if (got !== exp) begin
			abort_run($sformatf("Mismatch alarm_: got 0x%h, expected 0x%h", got, exp));
		end
	endtask

	// done holds a full cycle so the falling edge sees it stable
	always @(negedge clk) begin
		if (arst_n && done) begin
			check_word("w", w, exp_w);
			check_alarm(alarm_, exp_alarm_);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout: test did not finish within %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	// ------------------------------------------------------------
	// key stimulus
	// ------------------------------------------------------------

	// entered and left 1 ns after a rising edge
	task automatic press_key(key_cmd_t cmd, word_t word);
		key_cmd = cmd;
		kl = word;
		key_stb = 1'b1;
		@(posedge clk);
		#1;
		key_stb = 1'b0;
	endtask

	task automatic wait_done();
		while (!done) begin
			@(posedge clk);
			#1;
		end
		// done gone again after this edge
		@(posedge clk);
		#1;
	endtask

	task automatic run_key(key_cmd_t cmd, word_t word);
		exp_w = ref_key(cmd, word);
		exp_alarm_ = !model_alarm;
		press_key(cmd, word);
		// loads finish one cycle after acceptance
		if ((cmd == KEY_LOAD_AR || cmd == KEY_LOAD_NB) && !done) begin
			abort_run("done did not follow a load key after one cycle");
		end
		wait_done();
		if (done || busy) begin
			abort_run("done or busy stayed high after the key finished");
		end
	endtask

	// second key lands while the first is busy
	task automatic run_key_with_drop(key_cmd_t cmd, word_t word, word_t drop_word);
		exp_w = ref_key(cmd, word);
		exp_alarm_ = !model_alarm;
		press_key(cmd, word);
		if (!busy) begin
			abort_run("busy was low right after a fetch was accepted");
		end
		press_key(KEY_LOAD_AR, drop_word);
		wait_done();
	endtask

	// reset again and wait out the power-up clear
	// memory and last read data survive, registers and w do not
	task automatic reset_and_clear();
		arst_n = 1'b0;
		model_ar = '0;
		model_nb = '0;
		model_w = '0;
		model_alarm = 1'b0;
		exp_w = '0;
		exp_alarm_ = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		repeat (CLEAR_CYCLES + 2) @(posedge clk);
		#1;
	endtask

	initial begin
		word_t addr;
		word_t data;
		word_t first;
		word_t second;
		arst_n = 1'b0;
		key_stb = 1'b0;
		key_cmd = KEY_LOAD_AR;
		kl = '0;
		model_ar = '0;
		model_nb = '0;
		model_w = '0;
		model_alarm = 1'b0;
		exp_w = '0;
		exp_alarm_ = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		if (busy || done) begin
			abort_run("busy or done was active after reset");
		end
		check_alarm(alarm_, 1'b1);

		// keys during the clear are dropped
		@(posedge clk);
		#1;
		press_key(KEY_LOAD_AR, 16'h0055);
		repeat (6) begin
			@(posedge clk);
			#1;
			if (done) begin
				abort_run("done was raised for a key pressed during the power-up clear");
			end
		end
		repeat (CLEAR_CYCLES + 2) @(posedge clk);
		#1;
		data = rand_word();
		run_key(KEY_LOAD_NB, 16'h0000);
		run_key(KEY_LOAD_AR, 16'h0000);
		run_key(KEY_STORE, data);
		run_key(KEY_LOAD_AR, 16'h0000);
		run_key(KEY_FETCH, 16'h0000);

		// random store and fetch, both blocks
		for (int run = 0; run < RUNS; run++) begin
			for (int blk = 0; blk < 2; blk++) begin
				addr = rand_addr();
				data = rand_word();
				run_key(KEY_LOAD_NB, word_t'(blk));
				run_key(KEY_LOAD_AR, addr);
				run_key(KEY_STORE, data);
				run_key(KEY_LOAD_AR, addr);
				run_key(KEY_FETCH, 16'h0000);
			end
		end

		// auto-increment run in block 1
		addr = 16'h0040;
		run_key(KEY_LOAD_NB, 16'h0001);
		run_key(KEY_LOAD_AR, addr);
		for (int i = 0; i < RUN_LEN; i++) begin
			run_key(KEY_STORE, rand_word());
		end
		run_key(KEY_LOAD_AR, addr);
		for (int i = 0; i < RUN_LEN; i++) begin
			run_key(KEY_FETCH, 16'h0000);
		end

		// absent block 5
		// w cleared by reset while the bus stage still holds the last read word
		reset_and_clear();
		run_key(KEY_LOAD_NB, 16'h0005);
		run_key(KEY_FETCH, 16'h0000);
		check_alarm(alarm_, 1'b0);
		run_key(KEY_LOAD_NB, 16'h0000);

		// dropped key leaves ar alone
		first = rand_word();
		second = rand_word();
		run_key(KEY_LOAD_AR, 16'h0020);
		run_key(KEY_STORE, first);
		run_key(KEY_STORE, second);
		run_key(KEY_LOAD_AR, 16'h0020);
		run_key_with_drop(KEY_FETCH, 16'h0000, 16'h0000);
		run_key(KEY_FETCH, 16'h0000);
		check_word("w", w, second);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mera400_mem.f ====
design/bus_pkg.sv
design/panel_pkg.sv
design/puks.sv
design/panel_ctl.sv
design/bus_drv.sv
design/mem_ctl.sv
design/mera400_mem.sv
test/tb_mera400_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_mera400_mem
FILELIST  := mera400_mem.f
FLAGS     := --binary --timing -Wno-fatal
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)
